//--- build.f
source/core_pkg.sv
source/fetch_unit.sv
source/decode_unit.sv
source/id_ex_reg.sv
source/execute_unit.sv
source/mem_wb_unit.sv
source/mips_core.sv
dv/tb_mips_core.sv

//--- Bender.yml
package:
  name: mips_core

sources:
  - files:
      - source/core_pkg.sv
      - source/fetch_unit.sv
      - source/decode_unit.sv
      - source/id_ex_reg.sv
      - source/execute_unit.sv
      - source/mem_wb_unit.sv
      - source/mips_core.sv
  - target: test
    files:
      - dv/tb_mips_core.sv

//--- dv/tb_mips_core.sv
`timescale 1ns/10ps
`default_nettype none

module tb_mips_core;
    import core_pkg::*;

    localparam logic [5:0] addiu_op = 6'h09;
    localparam logic [5:0] ori_op   = 6'h0d;
    localparam logic [5:0] lui_op   = 6'h0f;
    localparam logic [5:0] lw_op    = 6'h23;
    localparam logic [5:0] sw_op    = 6'h2b;
    localparam logic [5:0] beq_op   = 6'h04;
    localparam logic [5:0] bne_op   = 6'h05;
    localparam logic [5:0] sll_fn   = 6'h00;
    localparam logic [5:0] addu_fn  = 6'h21;
    localparam logic [5:0] subu_fn  = 6'h23;
    localparam logic [5:0] and_fn   = 6'h24;
    localparam logic [5:0] or_fn    = 6'h25;
    localparam logic [5:0] slt_fn   = 6'h2a;
    localparam word_t syscall_word  = 32'h0000_000c;
    localparam word_t boot_pc       = 32'h0000_0000;

    logic       clk = 1'b0;
    logic       rst_n = 1'b0;
    word_t      imem_addr;
    word_t      imem_data;
    logic       wb_cyc;
    logic       wb_stb;
    logic       wb_we;
    word_t      wb_adr;
    word_t      wb_dat_o;
    logic [3:0] wb_sel;
    word_t      wb_dat_i = '0;
    logic       wb_ack = 1'b0;
    logic       halted;

    word_t       rom [256];
    word_t       dmem [256];
    word_t       got_adr [$];
    word_t       got_dat [$];
    word_t       exp_adr [$];
    word_t       exp_dat [$];
    int          value_errors = 0;
    int          other_errors = 0;
    int          late_bus = 0;
    int          next_slot = 0;
    int          pending = 0;
    int          wait_left = 0;
    logic        active = 1'b0;
    logic        random_delay = 1'b0;
    logic [31:0] lcg_state = 32'd89205;

    mips_core #(
        .reset_pc (boot_pc),
        .num_regs (32)
    ) mips_core_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .imem_addr (imem_addr),
        .imem_data (imem_data),
        .wb_cyc    (wb_cyc),
        .wb_stb    (wb_stb),
        .wb_we     (wb_we),
        .wb_adr    (wb_adr),
        .wb_dat_o  (wb_dat_o),
        .wb_sel    (wb_sel),
        .wb_dat_i  (wb_dat_i),
        .wb_ack    (wb_ack),
        .halted    (halted)
    );

    initial begin
        forever #10 clk = ~clk;
    end

    assign imem_data = rom[imem_addr[9:2]];

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state >> 16;
    endfunction

    function automatic word_t fill_word(input word_t adr);
        return (adr * 32'h9e37_79b1) ^ 32'h5a5a_a5a5;
    endfunction

    function automatic word_t sext(input logic [15:0] imm);
        return {{16{imm[15]}}, imm};
    endfunction

    function automatic word_t rtype(input logic [4:0] rs, input logic [4:0] rt,
                                    input logic [4:0] rd, input logic [4:0] shamt,
                                    input logic [5:0] funct);
        return {6'h00, rs, rt, rd, shamt, funct};
    endfunction

    function automatic word_t itype(input logic [5:0] op, input logic [4:0] rs,
                                    input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    // wishbone slave with 0 to 3 wait cycles before ack.
    always @(posedge clk) begin
        if (!rst_n) begin
            wb_ack <= 1'b0;
            active <= 1'b0;
        end else begin
            wb_ack <= 1'b0;
            if (wb_cyc && wb_stb && !wb_ack) begin
                if (!active)
                    pending = random_delay ? int'(next_random() % 4) : 0;
                else
                    pending = wait_left;
                if (pending != 0) begin
                    active    <= 1'b1;
                    wait_left <= pending - 1;
                end else begin
                    active <= 1'b0;
                    wb_ack <= 1'b1;
                    if ((wb_adr >= 32'h400) || (wb_adr[1:0] != 2'b00) || (wb_sel != 4'hf)) begin
                        $display("bus access out of range or partial select, adr %h sel %h",
                                 wb_adr, wb_sel);
                        other_errors++;
                    end else if (wb_we) begin
                        dmem[wb_adr[9:2]] <= wb_dat_o;
                        got_adr.push_back(wb_adr);
                        got_dat.push_back(wb_dat_o);
                    end else begin
                        wb_dat_i <= dmem[wb_adr[9:2]];
                    end
                end
            end
        end
    end

    always @(posedge clk) begin
        if (rst_n && halted && wb_cyc)
            late_bus++;
    end

    task automatic check_word(input string name, input core_pkg::word_t got,
                              input core_pkg::word_t exp);
        if (got !== exp) begin
            $display("FAILED %s: got %h, expected %h", name, got, exp);
            value_errors++;
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp) begin
            $display("FAILED %s: got %h, expected %h", name, got, exp);
            value_errors++;
        end
    endtask

    task automatic emit(input word_t instr);
        rom[next_slot] = instr;
        next_slot++;
    endtask

    task automatic expect_store(input word_t adr, input word_t dat);
        exp_adr.push_back(adr);
        exp_dat.push_back(dat);
    endtask

    // reset stays low until run_program releases it.
    task automatic begin_program();
        @(posedge clk);
        rst_n <= 1'b0;
        @(negedge clk);
        for (int i = 0; i < 256; i++) begin
            rom[i]  = '0;
            dmem[i] = fill_word(word_t'(i * 4));
        end
        got_adr.delete();
        got_dat.delete();
        exp_adr.delete();
        exp_dat.delete();
        next_slot = 0;
        late_bus  = 0;
    endtask

    task automatic compare_stores(input string name);
        int n;
        n = (got_adr.size() < exp_adr.size()) ? got_adr.size() : exp_adr.size();
        check_count({name, " store count"}, got_adr.size(), exp_adr.size());
        for (int i = 0; i < n; i++) begin
            check_word($sformatf("%s store %0d wb_adr", name, i), got_adr[i], exp_adr[i]);
            check_word($sformatf("%s store %0d wb_dat_o", name, i), got_dat[i], exp_dat[i]);
        end
    endtask

    task automatic run_program(input logic random_wait, input string name);
        int cycles;
        int low_cycles;
        random_delay = random_wait;
        check_word({name, " imem_addr in reset"}, imem_addr, boot_pc);
        if ((halted !== 1'b0) || (wb_cyc !== 1'b0)) begin
            $display("%s: halted or wb_cyc not low during reset", name);
            other_errors++;
        end
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        cycles     = 0;
        low_cycles = 0;
        @(negedge clk);
        while (!halted && cycles < 1000) begin
            @(negedge clk);
            cycles++;
        end
        if (!halted) begin
            $display("%s: timeout, halted did not rise within %0d cycles", name, cycles);
            other_errors++;
        end else begin
            for (int i = 0; i < 20; i++) begin
                @(negedge clk);
                if (!halted)
                    low_cycles++;
            end
            check_count({name, " cycles with halted low"}, low_cycles, 0);
        end
        check_count({name, " bus cycles after halt"}, late_bus, 0);
        compare_stores(name);
    endtask

    task automatic alu_ops();
        word_t       r [1:12];
        logic [15:0] off;
        begin_program();
        emit(itype(lui_op, 0, 1, 16'h1234));
        emit(itype(ori_op, 1, 1, 16'h5678));
        emit(itype(addiu_op, 0, 2, 16'hfffb));
        emit(itype(addiu_op, 0, 3, 16'h7ff0));
        emit(rtype(1, 3, 4, 0, addu_fn));
        emit(rtype(3, 1, 5, 0, subu_fn));
        emit(rtype(1, 3, 6, 0, and_fn));
        emit(rtype(2, 3, 7, 0, or_fn));
        emit(rtype(2, 3, 8, 0, slt_fn));
        emit(rtype(3, 2, 9, 0, slt_fn));
        emit(rtype(0, 1, 10, 4, sll_fn));
        emit(itype(ori_op, 0, 11, 16'h8001));
        emit(itype(addiu_op, 0, 12, 16'h8001));
        r[1]  = {16'h1234, 16'h0000} | 32'h0000_5678;
        r[2]  = sext(16'hfffb);
        r[3]  = sext(16'h7ff0);
        r[4]  = r[1] + r[3];
        r[5]  = r[3] - r[1];
        r[6]  = r[1] & r[3];
        r[7]  = r[2] | r[3];
        r[8]  = ($signed(r[2]) < $signed(r[3])) ? 32'd1 : 32'd0;
        r[9]  = ($signed(r[3]) < $signed(r[2])) ? 32'd1 : 32'd0;
        r[10] = r[1] << 4;
        r[11] = {16'h0000, 16'h8001};
        r[12] = sext(16'h8001);
        for (int i = 1; i <= 12; i++) begin
            off = 16'(32'h100 + 4 * (i - 1));
            emit(itype(sw_op, 0, 5'(i), off));
            expect_store({16'h0000, off}, r[i]);
        end
        emit(syscall_word);
        run_program(1'b0, "alu");
    endtask

    // each step depends on the one before.
    task automatic forwarding_chain(input logic random_wait);
        word_t r1, r2, r3, r4, r5, r6, r7;
        begin_program();
        emit(itype(addiu_op, 0, 1, 16'd3));
        emit(rtype(1, 1, 2, 0, addu_fn));
        emit(rtype(2, 1, 3, 0, addu_fn));
        emit(rtype(3, 2, 4, 0, subu_fn));
        emit(rtype(0, 4, 5, 3, sll_fn));
        emit(rtype(5, 3, 6, 0, or_fn));
        emit(itype(addiu_op, 0, 9, 16'h0200));
        emit(rtype(6, 6, 7, 0, addu_fn));
        emit(itype(sw_op, 9, 7, 16'd0));
        emit(itype(sw_op, 9, 6, 16'd4));
        emit(itype(sw_op, 9, 3, 16'd8));
        emit(itype(sw_op, 9, 5, 16'd12));
        emit(syscall_word);
        r1 = sext(16'd3);
        r2 = r1 + r1;
        r3 = r2 + r1;
        r4 = r3 - r2;
        r5 = r4 << 3;
        r6 = r5 | r3;
        r7 = r6 + r6;
        expect_store(32'h200, r7);
        expect_store(32'h204, r6);
        expect_store(32'h208, r3);
        expect_store(32'h20c, r5);
        run_program(random_wait, random_wait ? "forwarding with wait states" : "forwarding");
    endtask

    task automatic load_use(input logic random_wait);
        begin_program();
        emit(itype(addiu_op, 0, 1, 16'h0040));
        emit(itype(lw_op, 0, 2, 16'h0080));
        emit(itype(addiu_op, 2, 3, 16'h0111));
        emit(itype(sw_op, 0, 3, 16'h0300));
        emit(itype(lw_op, 0, 4, 16'h0084));
        emit(rtype(4, 1, 5, 0, addu_fn));
        emit(itype(sw_op, 0, 5, 16'h0304));
        emit(itype(lw_op, 0, 6, 16'h0088));
        emit(itype(sw_op, 0, 6, 16'h0308));
        emit(syscall_word);
        expect_store(32'h300, fill_word(32'h80) + sext(16'h0111));
        expect_store(32'h304, fill_word(32'h84) + 32'h40);
        expect_store(32'h308, fill_word(32'h88));
        run_program(random_wait, random_wait ? "load-use with wait states" : "load-use");
    endtask

    // stores at 0x3f0 and up sit on skipped paths.
    task automatic branches();
        begin_program();
        emit(itype(addiu_op, 0, 1, 16'd5));
        emit(itype(addiu_op, 0, 2, 16'd5));
        emit(itype(beq_op, 1, 2, 16'd3));
        emit(itype(sw_op, 0, 1, 16'h03f0));
        emit(itype(sw_op, 0, 2, 16'h03f4));
        emit(itype(sw_op, 0, 1, 16'h03f8));
        emit(itype(addiu_op, 0, 3, 16'd7));
        emit(itype(bne_op, 1, 2, 16'd2));
        emit(itype(sw_op, 0, 3, 16'h0310));
        emit(itype(sw_op, 0, 1, 16'h0314));
        emit(itype(bne_op, 3, 1, 16'd1));
        emit(itype(sw_op, 0, 3, 16'h03fc));
        emit(itype(sw_op, 0, 2, 16'h0318));
        emit(syscall_word);
        expect_store(32'h310, 32'd7);
        expect_store(32'h314, 32'd5);
        expect_store(32'h318, 32'd5);
        run_program(1'b0, "branches");
    endtask

    task automatic halt_stop();
        begin_program();
        emit(itype(addiu_op, 0, 1, 16'h0055));
        emit(itype(sw_op, 0, 1, 16'h0320));
        emit(syscall_word);
        emit(itype(sw_op, 0, 1, 16'h0324));
        emit(itype(sw_op, 0, 1, 16'h0328));
        expect_store(32'h320, 32'h55);
        run_program(1'b0, "halt");
    endtask

    initial begin
        for (int i = 0; i < 256; i++) begin
            rom[i]  = '0;
            dmem[i] = '0;
        end
        alu_ops();
        forwarding_chain(1'b0);
        load_use(1'b0);
        branches();
        forwarding_chain(1'b1);
        load_use(1'b1);
        halt_stop();
        $display("value mismatches: %0d, other errors: %0d", value_errors, other_errors);
        if ((value_errors == 0) && (other_errors == 0)) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- source/mips_core.sv
`timescale 1ns/10ps
`default_nettype none

module mips_core #(
    parameter core_pkg::word_t reset_pc = '0,
    parameter int              num_regs = 32
) (
    input  logic            clk,
    input  logic            rst_n,
    output core_pkg::word_t imem_addr,
    input  core_pkg::word_t imem_data,
    output logic            wb_cyc,
    output logic            wb_stb,
    output logic            wb_we,
    output core_pkg::word_t wb_adr,
    output core_pkg::word_t wb_dat_o,
    output logic [3:0]      wb_sel,
    input  core_pkg::word_t wb_dat_i,
    input  logic            wb_ack,
    output logic            halted
);
    import core_pkg::*;

    if_id_t  if_id;
    id_ex_t  id_ex_next;
    id_ex_t  id_ex;
    ex_mem_t ex_mem_next;
    ex_mem_t ex_mem;
    wb_t     wb;
    word_t   target;
    logic    redirect;
    logic    load_stall;
    logic    mem_busy;
    logic    freeze;
    logic    fetch_hold;
    logic    id_ex_flush;

    assign freeze      = mem_busy;
    assign fetch_hold  = freeze || load_stall || halted;
    assign id_ex_flush = load_stall || redirect;

    fetch_unit #(
        .reset_pc (reset_pc)
    ) fetch_unit_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .hold      (fetch_hold),
        .redirect  (redirect),
        .target    (target),
        .imem_addr (imem_addr),
        .imem_data (imem_data),
        .if_id     (if_id)
    );

    decode_unit #(
        .num_regs (num_regs)
    ) decode_unit_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .if_id      (if_id),
        .ex_stage   (id_ex),
        .wb         (wb),
        .id_ex_next (id_ex_next),
        .load_stall (load_stall)
    );

    id_ex_reg id_ex_reg_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .hold     (freeze),
        .flush    (id_ex_flush),
        .id_ex_in (id_ex_next),
        .id_ex    (id_ex)
    );

    execute_unit execute_unit_inst (
        .id_ex       (id_ex),
        .ex_mem      (ex_mem),
        .wb          (wb),
        .ex_mem_next (ex_mem_next),
        .redirect    (redirect),
        .target      (target)
    );

    mem_wb_unit mem_wb_unit_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .ex_mem_next (ex_mem_next),
        .ex_mem      (ex_mem),
        .wb          (wb),
        .mem_busy    (mem_busy),
        .halted      (halted),
        .wb_cyc      (wb_cyc),
        .wb_stb      (wb_stb),
        .wb_we       (wb_we),
        .wb_adr      (wb_adr),
        .wb_dat_o    (wb_dat_o),
        .wb_sel      (wb_sel),
        .wb_dat_i    (wb_dat_i),
        .wb_ack      (wb_ack)
    );

endmodule

`default_nettype wire

//--- source/mem_wb_unit.sv
`timescale 1ns/10ps
`default_nettype none

module mem_wb_unit (
    input  logic              clk,
    input  logic              rst_n,
    input  core_pkg::ex_mem_t ex_mem_next,
    output core_pkg::ex_mem_t ex_mem,
    output core_pkg::wb_t     wb,
    output logic              mem_busy,
    output logic              halted,
    output logic              wb_cyc,
    output logic              wb_stb,
    output logic              wb_we,
    output core_pkg::word_t   wb_adr,
    output core_pkg::word_t   wb_dat_o,
    output logic [3:0]        wb_sel,
    input  core_pkg::word_t   wb_dat_i,
    input  logic              wb_ack
);
    import core_pkg::*;

    typedef enum logic {
        bus_idle,
        bus_wait
    } bus_state_e;

    bus_state_e state;
    logic       is_load;
    logic       mem_req;
    logic       commit;

    assign is_load = (ex_mem.instr_class == cls_load);
    assign commit  = ex_mem.valid && !halted;
    assign mem_req = commit && (is_load || (ex_mem.instr_class == cls_store));

    // one idle cycle, then wait for ack.
    assign mem_busy = mem_req && !((state == bus_wait) && wb_ack);

    assign wb_cyc   = (state == bus_wait);
    assign wb_stb   = (state == bus_wait);
    assign wb_we    = (ex_mem.instr_class == cls_store);
    assign wb_adr   = ex_mem.alu_result;
    assign wb_dat_o = ex_mem.store_data;
    assign wb_sel   = 4'hf;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= bus_idle;
        end else begin
            unique case (state)
                bus_idle: if (mem_req) state <= bus_wait;
                bus_wait: if (wb_ack)  state <= bus_idle;
                default:               state <= bus_idle;
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ex_mem <= '0;
            wb     <= '0;
            halted <= 1'b0;
        end else if (!mem_busy) begin
            ex_mem       <= ex_mem_next;
            wb.valid     <= commit;
            wb.reg_write <= commit && ex_mem.reg_write;
            wb.dest      <= ex_mem.dest;
            wb.result    <= is_load ? wb_dat_i : ex_mem.alu_result;
            if (commit && (ex_mem.instr_class == cls_halt))
                halted <= 1'b1;
        end
    end

    assert property (@(posedge clk) disable iff (!rst_n)
        wb_stb |-> wb_cyc);

    // classic cycle, request held stable until ack.
    assert property (@(posedge clk) disable iff (!rst_n)
        (wb_stb && !wb_ack) |=> (wb_stb && $stable(wb_adr) && $stable(wb_we) &&
                                 $stable(wb_dat_o)));

endmodule

`default_nettype wire

//--- source/execute_unit.sv
`timescale 1ns/10ps
`default_nettype none

module execute_unit (
    input  core_pkg::id_ex_t  id_ex,
    input  core_pkg::ex_mem_t ex_mem,
    input  core_pkg::wb_t     wb,
    output core_pkg::ex_mem_t ex_mem_next,
    output logic              redirect,
    output core_pkg::word_t   target
);
    import core_pkg::*;

    word_t op_a;
    word_t op_b;
    word_t alu_b;
    word_t result;
    logic  equal;

    // youngest writer first. a load in memory never reaches here.
    function automatic word_t forward(input reg_idx_t idx, input word_t reg_val);
        if (idx == '0)
            return reg_val;
        if (ex_mem.valid && ex_mem.reg_write && (ex_mem.dest == idx) &&
            (ex_mem.instr_class != cls_load))
            return ex_mem.alu_result;
        if (wb.valid && wb.reg_write && (wb.dest == idx))
            return wb.result;
        return reg_val;
    endfunction

    always_comb begin
        op_a  = forward(id_ex.rs, id_ex.operand_a);
        op_b  = forward(id_ex.rt, id_ex.operand_b);
        alu_b = id_ex.use_imm ? id_ex.imm : op_b;
    end

    always_comb begin
        unique case (id_ex.alu_op)
            alu_add: result = op_a + alu_b;
            alu_sub: result = op_a - alu_b;
            alu_and: result = op_a & alu_b;
            alu_or:  result = op_a | alu_b;
            alu_slt: result = {31'b0, $signed(op_a) < $signed(alu_b)};
            alu_sll: result = op_b << id_ex.shamt;
            alu_lui: result = {alu_b[15:0], 16'h0000};
            default: result = '0;
        endcase
    end

    assign equal    = (op_a == op_b);
    assign redirect = id_ex.valid &&
                      (((id_ex.instr_class == cls_beq) && equal) ||
                       ((id_ex.instr_class == cls_bne) && !equal));
    assign target   = id_ex.pc_4 + {id_ex.imm[29:0], 2'b00};

    always_comb begin
        ex_mem_next.valid       = id_ex.valid;
        ex_mem_next.instr_class = id_ex.instr_class;
        ex_mem_next.reg_write   = id_ex.reg_write;
        ex_mem_next.dest        = id_ex.dest;
        ex_mem_next.alu_result  = result;
        ex_mem_next.store_data  = op_b;
    end

endmodule

`default_nettype wire

//--- source/id_ex_reg.sv
`timescale 1ns/10ps
`default_nettype none

module id_ex_reg (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             hold,
    input  logic             flush,
    input  core_pkg::id_ex_t id_ex_in,
    output core_pkg::id_ex_t id_ex
);
    import core_pkg::*;

    // freeze has priority, a flush under hold is dropped.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            id_ex <= '0;
        end else if (!hold) begin
            if (flush)
                id_ex <= '0;
            else
                id_ex <= id_ex_in;
        end
    end

    assert property (@(posedge clk) disable iff (!rst_n)
        hold |=> $stable(id_ex));

    assert property (@(posedge clk) disable iff (!rst_n)
        (flush && !hold) |=> !id_ex.valid);

endmodule

`default_nettype wire

//--- source/decode_unit.sv
`timescale 1ns/10ps
`default_nettype none

module decode_unit #(
    parameter int num_regs = 32
) (
    input  logic              clk,
    input  logic              rst_n,
    input  core_pkg::if_id_t  if_id,
    input  core_pkg::id_ex_t  ex_stage,
    input  core_pkg::wb_t     wb,
    output core_pkg::id_ex_t  id_ex_next,
    output logic              load_stall
);
    import core_pkg::*;

    localparam int idx_w = $clog2(num_regs);

    typedef enum logic [5:0] {
        fn_sll     = 6'h00,
        fn_syscall = 6'h0c,
        fn_addu    = 6'h21,
        fn_subu    = 6'h23,
        fn_and     = 6'h24,
        fn_or      = 6'h25,
        fn_slt     = 6'h2a
    } funct_e;

    word_t             regs [num_regs];
    logic [idx_w-1:0]  wr_idx;
    logic              rf_we;
    reg_idx_t          rs;
    reg_idx_t          rt;

    assign rs     = if_id.instr[25:21];
    assign rt     = if_id.instr[20:16];
    assign wr_idx = wb.dest[idx_w-1:0];
    assign rf_we  = wb.valid && wb.reg_write && (wr_idx != '0);

    // same-cycle writeback is bypassed.
    function automatic word_t read_port(input reg_idx_t idx);
        logic [idx_w-1:0] ridx;
        ridx = idx[idx_w-1:0];
        if (ridx == '0)
            return '0;
        if (rf_we && (wr_idx == ridx))
            return wb.result;
        return regs[ridx];
    endfunction

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < num_regs; i++)
                regs[i] <= '0;
        end else if (rf_we) begin
            regs[wr_idx] <= wb.result;
        end
    end

    always_comb begin
        logic sign_ext;
        sign_ext              = 1'b1;
        id_ex_next            = '0;
        id_ex_next.valid      = if_id.valid;
        id_ex_next.pc_4       = if_id.pc_4;
        id_ex_next.rs         = rs;
        id_ex_next.rt         = rt;
        id_ex_next.shamt      = if_id.instr[10:6];
        id_ex_next.operand_a  = read_port(rs);
        id_ex_next.operand_b  = read_port(rt);
        id_ex_next.alu_op     = alu_add;
        id_ex_next.instr_class = cls_alu;
        unique case (opcode_e'(if_id.instr[31:26]))
            op_special: begin
                id_ex_next.dest      = if_id.instr[15:11];
                id_ex_next.reg_write = 1'b1;
                unique case (funct_e'(if_id.instr[5:0]))
                    fn_addu: id_ex_next.alu_op = alu_add;
                    fn_subu: id_ex_next.alu_op = alu_sub;
                    fn_and:  id_ex_next.alu_op = alu_and;
                    fn_or:   id_ex_next.alu_op = alu_or;
                    fn_slt:  id_ex_next.alu_op = alu_slt;
                    fn_sll:  id_ex_next.alu_op = alu_sll;
                    fn_syscall: begin
                        id_ex_next.instr_class = cls_halt;
                        id_ex_next.reg_write   = 1'b0;
                    end
                    default: id_ex_next.reg_write = 1'b0;
                endcase
            end
            op_addiu, op_ori, op_lui, op_lw: begin
                id_ex_next.dest      = rt;
                id_ex_next.reg_write = 1'b1;
                id_ex_next.use_imm   = 1'b1;
                sign_ext             = (if_id.instr[31:26] == op_addiu) ||
                                       (if_id.instr[31:26] == op_lw);
                if (if_id.instr[31:26] == op_ori)
                    id_ex_next.alu_op = alu_or;
                else if (if_id.instr[31:26] == op_lui)
                    id_ex_next.alu_op = alu_lui;
                else if (if_id.instr[31:26] == op_lw)
                    id_ex_next.instr_class = cls_load;
            end
            op_sw: begin
                id_ex_next.use_imm     = 1'b1;
                id_ex_next.instr_class = cls_store;
            end
            op_beq:  id_ex_next.instr_class = cls_beq;
            op_bne:  id_ex_next.instr_class = cls_bne;
            default: id_ex_next.reg_write = 1'b0;
        endcase
        id_ex_next.imm = sign_ext ? {{16{if_id.instr[15]}}, if_id.instr[15:0]}
                                  : {16'h0000, if_id.instr[15:0]};
    end

    // load in execute feeding the instruction in decode.
    assign load_stall = if_id.valid && ex_stage.valid &&
                        (ex_stage.instr_class == cls_load) && (ex_stage.dest != '0) &&
                        ((ex_stage.dest == rs) || (ex_stage.dest == rt));

    assert property (@(posedge clk) disable iff (!rst_n)
        (wb.valid && wb.reg_write && wr_idx == '0) |=> $stable(regs[0]));

endmodule

`default_nettype wire

//--- source/fetch_unit.sv
`timescale 1ns/10ps
`default_nettype none

module fetch_unit #(
    parameter core_pkg::word_t reset_pc = '0
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             hold,
    input  logic             redirect,
    input  core_pkg::word_t  target,
    output core_pkg::word_t  imem_addr,
    input  core_pkg::word_t  imem_data,
    output core_pkg::if_id_t if_id
);
    import core_pkg::*;

    word_t pc;
    word_t pc_4;

    assign pc_4      = pc + 32'd4;
    assign imem_addr = pc;

    // hold wins over redirect, the branch stays in execute until released.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc    <= reset_pc;
            if_id <= '0;
        end else if (!hold) begin
            if (redirect) begin
                pc          <= target;
                if_id.valid <= 1'b0;
            end else begin
                pc    <= pc_4;
                if_id <= '{valid: 1'b1, pc_4: pc_4, instr: imem_data};
            end
        end
    end

endmodule

`default_nettype wire

//--- source/core_pkg.sv
`default_nettype none

package core_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_idx_t;

    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_slt,
        alu_sll,
        alu_lui
    } alu_op_e;

    typedef enum logic [2:0] {
        cls_alu,
        cls_load,
        cls_store,
        cls_beq,
        cls_bne,
        cls_halt
    } instr_class_e;

    // major opcode field, bits 31:26.
    typedef enum logic [5:0] {
        op_special = 6'h00,
        op_beq     = 6'h04,
        op_bne     = 6'h05,
        op_addiu   = 6'h09,
        op_ori     = 6'h0d,
        op_lui     = 6'h0f,
        op_lw      = 6'h23,
        op_sw      = 6'h2b
    } opcode_e;

    typedef struct packed {
        logic  valid;
        word_t pc_4;
        word_t instr;
    } if_id_t;

    typedef struct packed {
        logic         valid;
        word_t        pc_4;
        reg_idx_t     rs;
        reg_idx_t     rt;
        reg_idx_t     dest;
        logic [4:0]   shamt;
        word_t        imm;
        logic         use_imm;
        word_t        operand_a;
        word_t        operand_b;
        alu_op_e      alu_op;
        instr_class_e instr_class;
        logic         reg_write;
    } id_ex_t;

    typedef struct packed {
        logic         valid;
        instr_class_e instr_class;
        logic         reg_write;
        reg_idx_t     dest;
        word_t        alu_result;
        word_t        store_data;
    } ex_mem_t;

    // also the forwarding source for decode and execute.
    typedef struct packed {
        logic     valid;
        logic     reg_write;
        reg_idx_t dest;
        word_t    result;
    } wb_t;

endpackage

`default_nettype wire
